/* design/lstm_defines.svh */
`ifndef LSTM_DEFINES_SVH
`define LSTM_DEFINES_SVH

// Fixed-point format Q6.11 with one sign bit
`define LSTM_QN 6
`define LSTM_QM 11
`define LSTM_WIDTH (`LSTM_QN + `LSTM_QM + 1)

// Layer sizes
`define LSTM_INPUT_SZ 2
`define LSTM_HIDDEN_SZ 4

// Input columns, then recurrent columns, then the bias column
`define LSTM_NUM_COLS (`LSTM_INPUT_SZ + `LSTM_HIDDEN_SZ + 1)

// Accumulate phase plus activate, update and the output register
`define LSTM_LATENCY (`LSTM_NUM_COLS + 3)

`endif

/* design/lstmFixedPkg.sv */
`include "lstm_defines.svh"

package lstmFixedPkg;

    // One signed Q6.11 word
    typedef logic signed [`LSTM_WIDTH-1:0] fixed_t;

    typedef fixed_t [`LSTM_INPUT_SZ-1:0] inputVec_t;
    typedef fixed_t [`LSTM_HIDDEN_SZ-1:0] hiddenVec_t;

    // Pre-activations of all four gates
    typedef struct packed {
        hiddenVec_t z;
        hiddenVec_t i;
        hiddenVec_t f;
        hiddenVec_t o;
    } gatePre_t;

    localparam fixed_t FIXED_ONE = fixed_t'(1 << `LSTM_QM);

    // Full product, arithmetic shift back to Q6.11, truncated to the word
    function automatic fixed_t fixedMul(input fixed_t a, input fixed_t b);
        logic signed [2*`LSTM_WIDTH-1:0] full;
        full = a * b;
        return fixed_t'(full >>> `LSTM_QM);
    endfunction

endpackage

/* design/lstmControlPkg.sv */
`include "lstm_defines.svh"

package lstmControlPkg;

    import lstmFixedPkg::*;

    localparam int ROW_BITS = $clog2(`LSTM_HIDDEN_SZ);
    localparam int COL_BITS = $clog2(`LSTM_NUM_COLS);

    typedef enum logic [1:0] {
        IDLE,
        ACCUMULATE,
        ACTIVATE,
        UPDATE
    } ctrlState_t;

    typedef enum logic [1:0] {
        GATE_Z,
        GATE_I,
        GATE_F,
        GATE_O
    } gateSel_t;

    // One weight word into one gate memory
    typedef struct packed {
        logic                enable;
        gateSel_t            gate;
        logic [ROW_BITS-1:0] row;
        logic [COL_BITS-1:0] column;
        fixed_t              value;
    } weightWrite_t;

    // Column step broadcast to every gate
    typedef struct packed {
        logic                clear;
        logic                accumulate;
        logic [COL_BITS-1:0] column;
        fixed_t              operand;
    } macStep_t;

endpackage

/* design/gateUnit.sv */
`include "lstm_defines.svh"

module gateUnit
    import lstmFixedPkg::*;
    import lstmControlPkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  gateSel_t     gate,
    input  weightWrite_t weightWrite,
    input  macStep_t     macStep,
    output hiddenVec_t   preActivation
);

    // Rows are hidden units, columns are inputs, hidden state and bias
    fixed_t weights [`LSTM_HIDDEN_SZ][`LSTM_NUM_COLS];

    hiddenVec_t products;
    hiddenVec_t accum;
    logic       writeHit;

    assign writeHit = weightWrite.enable && (weightWrite.gate == gate);

    always_ff @(posedge clock) begin
        if (writeHit) begin
            weights[weightWrite.row][weightWrite.column] <= weightWrite.value;
        end
    end

    // One multiplier per row, all reading the same column
    always_comb begin
        for (int r = 0; r < `LSTM_HIDDEN_SZ; r++) begin
            products[r] = fixedMul(weights[r][macStep.column], macStep.operand);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            accum <= '0;
        end else if (macStep.accumulate) begin
            for (int r = 0; r < `LSTM_HIDDEN_SZ; r++) begin
                // First column restarts the sum
                if (macStep.clear) begin
                    accum[r] <= products[r];
                end else begin
                    accum[r] <= accum[r] + products[r];
                end
            end
        end
    end

    assign preActivation = accum;

endmodule

/* design/cellUpdate.sv */
`include "lstm_defines.svh"

module cellUpdate
    import lstmFixedPkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  gatePre_t   gates,
    input  logic       activate,
    input  logic       update,
    output hiddenVec_t hiddenState
);

    localparam fixed_t MINUS_ONE = -FIXED_ONE;
    localparam fixed_t HALF = FIXED_ONE >>> 1;

    hiddenVec_t tanhZ;
    hiddenVec_t sigI;
    hiddenVec_t sigF;
    hiddenVec_t sigO;
    hiddenVec_t cellState;
    hiddenVec_t nextCell;
    hiddenVec_t nextHidden;

    function automatic fixed_t hardTanh(input fixed_t x);
        if (x > FIXED_ONE) begin
            return FIXED_ONE;
        end else if (x < MINUS_ONE) begin
            return MINUS_ONE;
        end
        return x;
    endfunction

    // Slope of a quarter is an arithmetic shift by two
    function automatic fixed_t hardSigmoid(input fixed_t x);
        fixed_t y;
        y = (x >>> 2) + HALF;
        if (y > FIXED_ONE) begin
            return FIXED_ONE;
        end else if (y < 0) begin
            return '0;
        end
        return y;
    endfunction

    // Activations, held until the update step
    always_ff @(posedge clock) begin
        if (activate) begin
            for (int k = 0; k < `LSTM_HIDDEN_SZ; k++) begin
                tanhZ[k] <= hardTanh(gates.z[k]);
                sigI[k]  <= hardSigmoid(gates.i[k]);
                sigF[k]  <= hardSigmoid(gates.f[k]);
                sigO[k]  <= hardSigmoid(gates.o[k]);
            end
        end
    end

    always_comb begin
        for (int k = 0; k < `LSTM_HIDDEN_SZ; k++) begin
            nextCell[k] = fixedMul(tanhZ[k], sigI[k]) + fixedMul(cellState[k], sigF[k]);
            nextHidden[k] = fixedMul(hardTanh(nextCell[k]), sigO[k]);
        end
    end

    // Recurrent state
    always_ff @(posedge clock) begin
        if (reset) begin
            cellState   <= '0;
            hiddenState <= '0;
        end else if (update) begin
            cellState   <= nextCell;
            hiddenState <= nextHidden;
        end
    end

endmodule

/* design/lstmController.sv */
`include "lstm_defines.svh"

module lstmController
    import lstmFixedPkg::*;
    import lstmControlPkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       newSample,
    input  inputVec_t  inputVec,
    input  hiddenVec_t hiddenState,
    output macStep_t   macStep,
    output logic       activate,
    output logic       update,
    output logic       outputValid
);

    localparam logic [COL_BITS-1:0] LAST_COL = COL_BITS'(`LSTM_NUM_COLS - 1);

    ctrlState_t          state;
    logic [COL_BITS-1:0] column;
    inputVec_t           sampleVec;
    fixed_t              operand;
    logic                accept;

    // Requests outside IDLE are dropped
    assign accept = (state == IDLE) && newSample;

    always_ff @(posedge clock) begin
        if (reset) begin
            state       <= IDLE;
            column      <= '0;
            outputValid <= 1'b0;
        end else begin
            outputValid <= (state == UPDATE);
            case (state)
                IDLE: begin
                    if (accept) begin
                        state  <= ACCUMULATE;
                        column <= '0;
                    end
                end
                ACCUMULATE: begin
                    if (column == LAST_COL) begin
                        state <= ACTIVATE;
                    end else begin
                        column <= column + 1'b1;
                    end
                end
                ACTIVATE: state <= UPDATE;
                default:  state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            sampleVec <= inputVec;
        end
    end

    // Input words, then the previous hidden vector, then the bias
    always_comb begin
        if (column < `LSTM_INPUT_SZ) begin
            operand = sampleVec[column];
        end else if (column < `LSTM_INPUT_SZ + `LSTM_HIDDEN_SZ) begin
            operand = hiddenState[column - `LSTM_INPUT_SZ];
        end else begin
            operand = FIXED_ONE;
        end
    end

    assign macStep.accumulate = (state == ACCUMULATE);
    assign macStep.clear      = (state == ACCUMULATE) && (column == '0);
    assign macStep.column     = column;
    assign macStep.operand    = operand;

    assign activate = (state == ACTIVATE);
    assign update   = (state == UPDATE);

endmodule

/* design/lstmCell.sv */
`include "lstm_defines.svh"

module lstmCell
    import lstmFixedPkg::*;
    import lstmControlPkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  logic         newSample,
    input  inputVec_t    inputVec,
    input  weightWrite_t weightWrite,
    output hiddenVec_t   hiddenOut,
    output logic         outputValid
);

    macStep_t      macStep;
    logic          activate;
    logic          update;
    wire gatePre_t gates;

    lstmController controller_i (
        .clock       (clock),
        .reset       (reset),
        .newSample   (newSample),
        .inputVec    (inputVec),
        .hiddenState (hiddenOut),
        .macStep     (macStep),
        .activate    (activate),
        .update      (update),
        .outputValid (outputValid)
    );

    // Four identical gates, told apart only by their gate identity
    gateUnit gateZ_i (
        .clock         (clock),
        .reset         (reset),
        .gate          (GATE_Z),
        .weightWrite   (weightWrite),
        .macStep       (macStep),
        .preActivation (gates.z)
    );

    gateUnit gateI_i (
        .clock         (clock),
        .reset         (reset),
        .gate          (GATE_I),
        .weightWrite   (weightWrite),
        .macStep       (macStep),
        .preActivation (gates.i)
    );

    gateUnit gateF_i (
        .clock         (clock),
        .reset         (reset),
        .gate          (GATE_F),
        .weightWrite   (weightWrite),
        .macStep       (macStep),
        .preActivation (gates.f)
    );

    gateUnit gateO_i (
        .clock         (clock),
        .reset         (reset),
        .gate          (GATE_O),
        .weightWrite   (weightWrite),
        .macStep       (macStep),
        .preActivation (gates.o)
    );

    cellUpdate cellUpdate_i (
        .clock       (clock),
        .reset       (reset),
        .gates       (gates),
        .activate    (activate),
        .update      (update),
        .hiddenState (hiddenOut)
    );

endmodule

/* verification/clockGen.sv */
module clockGen (
    output logic clock,
    output logic reset
);

    localparam int HALF_PERIOD = 4;
    localparam int RESET_CYCLES = 3;

    initial begin
        clock = 1'b0;
        forever #HALF_PERIOD clock = ~clock;
    end

    // Released on a falling edge, like every other stimulus
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    end

endmodule

/* verification/lstmCell_properties.sv */
`include "lstm_defines.svh"

module lstmCell_properties
    import lstmFixedPkg::*;
    import lstmControlPkg::*;
(
    input logic       clock,
    input logic       reset,
    input logic       newSample,
    input ctrlState_t state,
    input hiddenVec_t hiddenOut,
    input logic       outputValid
);

    localparam int QUIET_CYCLES = `LSTM_LATENCY - 1;

    logic accepted;

    assign accepted = newSample && (state == IDLE);

    singleCycleValid: assert property (
        @(posedge clock) disable iff (reset) outputValid |=> !outputValid
    ) else $error("outputValid held high for two cycles");

    validAfterLatency: assert property (
        @(posedge clock) disable iff (reset)
        accepted |-> ##1 (!outputValid) [*QUIET_CYCLES] ##1 outputValid
    ) else $error("outputValid not seen exactly at the expected latency");

    // The hidden vector moves only together with the output strobe
    stableHidden: assert property (
        @(posedge clock) disable iff (reset)
        (!$past(reset) && $changed(hiddenOut)) |-> outputValid
    ) else $error("hiddenOut changed without outputValid");

    quietAfterReset: assert property (
        @(posedge clock) reset |=> !outputValid
    ) else $error("outputValid high in the cycle after reset");

endmodule

bind lstmCell lstmCell_properties properties_i (
    .clock       (clock),
    .reset       (reset),
    .newSample   (newSample),
    .state       (controller_i.state),
    .hiddenOut   (hiddenOut),
    .outputValid (outputValid)
);

/* verification/lstmCellTb.sv */
`include "lstm_defines.svh"

module lstmCellTb
    import lstmFixedPkg::*;
    import lstmControlPkg::*;
();

    localparam int NUM_ENTRIES = 7;
    localparam int NUM_LOADS = 2;
    localparam int NUM_GATES = 4;
    localparam int WEIGHT_WORDS = NUM_GATES * `LSTM_HIDDEN_SZ * `LSTM_NUM_COLS;
    localparam int CYCLE_LIMIT =
        NUM_ENTRIES * (`LSTM_LATENCY + 20) + NUM_LOADS * WEIGHT_WORDS + 100;

    localparam logic [1:0] KEEP_WEIGHTS = 2'd0;
    localparam logic [1:0] LOAD_RANDOM = 2'd1;
    localparam logic [1:0] LOAD_SATURATING = 2'd2;

    localparam fixed_t ONE = fixed_t'(1 << `LSTM_QM);
    localparam fixed_t MINUS_ONE = -ONE;
    localparam fixed_t HALF = fixed_t'(1 << (`LSTM_QM - 1));
    localparam fixed_t QUARTER = fixed_t'(1 << (`LSTM_QM - 2));
    localparam fixed_t BIG_BIAS = fixed_t'(6 << `LSTM_QM);

    typedef struct packed {
        logic [1:0] reload;
        logic       doReset;
        logic       extraSample;
        inputVec_t  inputVec;
        hiddenVec_t expected;
    } stimEntry_t;

    logic         clock;
    logic         reset;
    logic         powerOnReset;
    logic         softReset;
    logic         newSample;
    inputVec_t    inputVec;
    weightWrite_t weightWrite;
    hiddenVec_t   hiddenOut;
    logic         outputValid;

    stimEntry_t stimTable [NUM_ENTRIES];
    fixed_t     entryWeights [NUM_ENTRIES][NUM_GATES][`LSTM_HIDDEN_SZ][`LSTM_NUM_COLS];
    fixed_t     modelWeights [NUM_GATES][`LSTM_HIDDEN_SZ][`LSTM_NUM_COLS];
    hiddenVec_t modelCell;
    hiddenVec_t modelHidden;

    int seed;
    int errorCount;
    int checkCount;
    int validCount;
    int cycleCount;

    clockGen clockGen_i (
        .clock (clock),
        .reset (powerOnReset)
    );

    assign reset = powerOnReset | softReset;

    lstmCell lstmCell_i (
        .clock       (clock),
        .reset       (reset),
        .newSample   (newSample),
        .inputVec    (inputVec),
        .weightWrite (weightWrite),
        .hiddenOut   (hiddenOut),
        .outputValid (outputValid)
    );

    // Q6.11 product: full product, arithmetic shift, keep the low word
    function automatic fixed_t qMul(input fixed_t a, input fixed_t b);
        longint full;
        full = longint'(a) * longint'(b);
        return fixed_t'(full >>> `LSTM_QM);
    endfunction

    function automatic fixed_t clampTanh(input fixed_t x);
        if (x > ONE) begin
            return ONE;
        end
        if (x < MINUS_ONE) begin
            return MINUS_ONE;
        end
        return x;
    endfunction

    function automatic fixed_t clampSigmoid(input fixed_t x);
        fixed_t y;
        y = qMul(x, QUARTER) + HALF;
        if (y > ONE) begin
            return ONE;
        end
        if (y < 0) begin
            return '0;
        end
        return y;
    endfunction

    function automatic stimEntry_t makeEntry(input logic [1:0] reload, input logic doReset,
                                             input logic extra, input int in0, input int in1);
        stimEntry_t e;
        e = '0;
        e.reload = reload;
        e.doReset = doReset;
        e.extraSample = extra;
        e.inputVec[0] = fixed_t'(in0);
        e.inputVec[1] = fixed_t'(in1);
        return e;
    endfunction

    task automatic fillWeights(input int n, input logic saturate);
        for (int g = 0; g < NUM_GATES; g++) begin
            for (int r = 0; r < `LSTM_HIDDEN_SZ; r++) begin
                for (int c = 0; c < `LSTM_NUM_COLS; c++) begin
                    entryWeights[n][g][r][c] = fixed_t'($random(seed) % 1024);
                    // Bias sign alternates so every clamp is reached
                    if (saturate && c == `LSTM_NUM_COLS - 1) begin
                        entryWeights[n][g][r][c] = ((g + r) % 2 == 0) ? BIG_BIAS : -BIG_BIAS;
                    end
                    modelWeights[g][r][c] = entryWeights[n][g][r][c];
                end
            end
        end
    endtask

    task automatic predictSample(input inputVec_t x, output hiddenVec_t h);
        fixed_t     pre [NUM_GATES][`LSTM_HIDDEN_SZ];
        fixed_t     operand;
        hiddenVec_t nextCell;
        for (int g = 0; g < NUM_GATES; g++) begin
            for (int r = 0; r < `LSTM_HIDDEN_SZ; r++) begin
                pre[g][r] = '0;
                for (int c = 0; c < `LSTM_NUM_COLS; c++) begin
                    if (c < `LSTM_INPUT_SZ) begin
                        operand = x[c];
                    end else if (c < `LSTM_INPUT_SZ + `LSTM_HIDDEN_SZ) begin
                        operand = modelHidden[c - `LSTM_INPUT_SZ];
                    end else begin
                        operand = ONE;
                    end
                    pre[g][r] = pre[g][r] + qMul(modelWeights[g][r][c], operand);
                end
            end
        end
        for (int r = 0; r < `LSTM_HIDDEN_SZ; r++) begin
            nextCell[r] = qMul(clampTanh(pre[0][r]), clampSigmoid(pre[1][r]))
                        + qMul(modelCell[r], clampSigmoid(pre[2][r]));
            h[r] = qMul(clampTanh(nextCell[r]), clampSigmoid(pre[3][r]));
        end
        modelCell = nextCell;
        modelHidden = h;
    endtask

    task automatic buildTable();
        hiddenVec_t h;
        stimTable[0] = makeEntry(LOAD_RANDOM, 1'b0, 1'b0, 1200, -800);
        stimTable[1] = makeEntry(KEEP_WEIGHTS, 1'b0, 1'b0, -1500, 400);
        stimTable[2] = makeEntry(KEEP_WEIGHTS, 1'b0, 1'b0, 700, 1900);
        stimTable[3] = makeEntry(KEEP_WEIGHTS, 1'b1, 1'b0, 1200, -800);
        stimTable[4] = makeEntry(KEEP_WEIGHTS, 1'b0, 1'b1, -300, -1000);
        stimTable[5] = makeEntry(LOAD_SATURATING, 1'b0, 1'b0, 2048, -2048);
        stimTable[6] = makeEntry(KEEP_WEIGHTS, 1'b0, 1'b0, -1024, 1536);
        seed = 32'h07199bfd;
        modelCell = '0;
        modelHidden = '0;
        for (int n = 0; n < NUM_ENTRIES; n++) begin
            if (stimTable[n].doReset) begin
                modelCell = '0;
                modelHidden = '0;
            end
            if (stimTable[n].reload != KEEP_WEIGHTS) begin
                fillWeights(n, stimTable[n].reload == LOAD_SATURATING);
            end
            predictSample(stimTable[n].inputVec, h);
            stimTable[n].expected = h;
        end
    endtask

    task automatic pulseReset();
        @(negedge clock);
        softReset = 1'b1;
        repeat (2) @(negedge clock);
        softReset = 1'b0;
    endtask

    task automatic loadWeights(input int n);
        for (int g = 0; g < NUM_GATES; g++) begin
            for (int r = 0; r < `LSTM_HIDDEN_SZ; r++) begin
                for (int c = 0; c < `LSTM_NUM_COLS; c++) begin
                    @(negedge clock);
                    weightWrite.enable = 1'b1;
                    weightWrite.gate = gateSel_t'(g);
                    weightWrite.row = ROW_BITS'(r);
                    weightWrite.column = COL_BITS'(c);
                    weightWrite.value = entryWeights[n][g][r][c];
                end
            end
        end
        @(negedge clock);
        weightWrite = '0;
    endtask

    task automatic runSample(input int n);
        stimEntry_t entry;
        fixed_t     expWord;
        fixed_t     actWord;
        entry = stimTable[n];
        @(negedge clock);
        newSample = 1'b1;
        inputVec = entry.inputVec;
        for (int k = 1; k <= `LSTM_LATENCY; k++) begin
            @(negedge clock);
            // A second request lands in the middle of the accumulate phase
            newSample = entry.extraSample && (k == 3);
            if (k < `LSTM_LATENCY && outputValid) begin
                $display("Entry %0d: outputValid rose after only %0d cycles at time %0t",
                         n, k, $time);
                errorCount++;
            end
        end
        checkCount++;
        if (outputValid !== 1'b1) begin
            $display("Entry %0d: outputValid missing %0d cycles after newSample at time %0t",
                     n, `LSTM_LATENCY, $time);
            errorCount++;
        end
        for (int k = 0; k < `LSTM_HIDDEN_SZ; k++) begin
            expWord = entry.expected[k];
            actWord = hiddenOut[k];
            checkCount++;
            if (actWord !== expWord) begin
                $display("ERROR t=%0t hiddenOut[%0d]: expected %0d, actual %0d",
                         $time, k, expWord, actWord);
                errorCount++;
            end
        end
        if (entry.extraSample) begin
            repeat (`LSTM_LATENCY) @(negedge clock);
        end
    endtask

    always @(negedge clock) begin
        if (outputValid === 1'b1) begin
            validCount++;
        end
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < CYCLE_LIMIT) begin
            @(posedge clock);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Test failures found");
        $finish;
    end

    initial begin
        newSample = 1'b0;
        inputVec = '0;
        weightWrite = '0;
        softReset = 1'b0;
        errorCount = 0;
        checkCount = 0;
        validCount = 0;
        buildTable();
        wait (powerOnReset === 1'b1);
        wait (powerOnReset === 1'b0);
        for (int n = 0; n < NUM_ENTRIES; n++) begin
            if (stimTable[n].doReset) begin
                pulseReset();
            end
            if (stimTable[n].reload != KEEP_WEIGHTS) begin
                loadWeights(n);
            end
            runSample(n);
        end
        repeat (2) @(negedge clock);
        checkCount++;
        if (validCount != NUM_ENTRIES) begin
            $display("Saw %0d outputValid pulses where %0d samples were accepted",
                     validCount, NUM_ENTRIES);
            errorCount++;
        end
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+design
design/lstmFixedPkg.sv
design/lstmControlPkg.sv
design/gateUnit.sv
design/cellUpdate.sv
design/lstmController.sv
design/lstmCell.sv
verification/clockGen.sv
verification/lstmCell_properties.sv
verification/lstmCellTb.sv

/* Bender.yml */
package:
  name: lstm_cell

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/lstmFixedPkg.sv
      - design/lstmControlPkg.sv
      - design/gateUnit.sv
      - design/cellUpdate.sv
      - design/lstmController.sv
      - design/lstmCell.sv
  - target: test
    include_dirs:
      - design
    files:
      - verification/clockGen.sv
      - verification/lstmCell_properties.sv
      - verification/lstmCellTb.sv
